/* source/hsid_config.svh */
`ifndef HSID_CONFIG_SVH
`define HSID_CONFIG_SVH

// Spectral word layout
`define HSID_WORD_WIDTH 32
`define HSID_DATA_WIDTH 8

// Band address width with the sample select in the two low bits
`define HSID_HSP_BANDS_WIDTH 8

// Library size and vector index
`define HSID_HSP_LIBRARY_WIDTH 6

// Reference FIFO entries and the sender's credits after reset
`define HSID_REF_FIFO_DEPTH 8

// Room for 63 packs of four full-scale squared errors
`define HSID_MSE_WIDTH 24

`endif

/* source/hsid_pkg.sv */
`default_nettype none

`include "hsid_config.svh"

package hsid_pkg;

  typedef enum logic [2:0] {
    IDLE,          // Waiting for start
    READ_MEASURE,  // Measure vector loading
    COMPUTE_MSE,   // Streaming reference vectors
    WAIT_MSE,      // Pipeline draining
    COMPARE_MSE,   // Last distance being compared
    DONE           // Result pulse
  } hsid_main_state_t;

  localparam int HSID_SAMPLES_PER_WORD = `HSID_WORD_WIDTH / `HSID_DATA_WIDTH;

  // One band pack, seen as a plain word or as its band samples
  typedef union packed {
    logic [`HSID_WORD_WIDTH-1:0] raw;
    logic [HSID_SAMPLES_PER_WORD-1:0][`HSID_DATA_WIDTH-1:0] samples;  // Lowest band in [0]
  } hsid_word_u;

endpackage

`default_nettype wire

/* source/hsid_main_fsm.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_main_fsm
  import hsid_pkg::*;
#(
  parameter int HSP_BANDS_WIDTH   = `HSID_HSP_BANDS_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = `HSID_HSP_LIBRARY_WIDTH,
  localparam int PACK_WIDTH =
    HSP_BANDS_WIDTH - $clog2(`HSID_WORD_WIDTH / `HSID_DATA_WIDTH)
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [HSP_LIBRARY_WIDTH-1:0] hsi_library_size,     // Vectors in the library
  input  logic [PACK_WIDTH-1:0]        band_pack_threshold,  // Packs per vector
  input  logic                         fifo_measure_complete,
  input  logic                         fifo_ref_empty,
  input  logic                         msi_valid,
  input  logic                         msi_comparison_valid,
  input  logic                         start,
  output hsid_main_state_t             state,
  output logic [HSP_LIBRARY_WIDTH-1:0] vctr_count,           // Index of the vector on the data path
  output logic                         band_pack_start,
  output logic                         band_pack_last,
  output logic                         band_pack_valid,
  output logic                         vctr_last,            // Reading the last vector
  output logic                         fifo_both_read_en,
  output logic                         done,
  output logic                         idle
);

  hsid_main_state_t             next_state;
  logic [PACK_WIDTH-1:0]        pack_count;     // Pack being read in the current vector
  logic [HSP_LIBRARY_WIDTH-1:0] rd_vctr_count;  // Vector being read, leads vctr_count
  logic                         pack_last_rd;

  assign fifo_both_read_en = (state == COMPUTE_MSE) && !fifo_ref_empty;
  assign pack_last_rd      = (pack_count == band_pack_threshold - 1'b1);
  assign vctr_last         = (rd_vctr_count == hsi_library_size - 1'b1);

  assign idle = (state == IDLE);
  assign done = (state == DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Read side counts packs and vectors as they leave the buffers.
  // vctr_count moves on the registered last flag so it stays aligned
  // with the buffer read data.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pack_count    <= '0;
      rd_vctr_count <= '0;
      vctr_count    <= '0;
    end else if (state == IDLE) begin
      pack_count    <= '0;  // Fresh counts for every run
      rd_vctr_count <= '0;
      vctr_count    <= '0;
    end else begin
      if (fifo_both_read_en) begin
        if (pack_last_rd) begin
          pack_count    <= '0;
          rd_vctr_count <= rd_vctr_count + 1'b1;
        end else begin
          pack_count <= pack_count + 1'b1;
        end
      end
      if (band_pack_last) begin
        vctr_count <= vctr_count + 1'b1;
      end
    end
  end

  // Flags line up with the registered buffer outputs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      band_pack_valid <= 1'b0;
      band_pack_start <= 1'b0;
      band_pack_last  <= 1'b0;
    end else begin
      band_pack_valid <= fifo_both_read_en;
      band_pack_start <= fifo_both_read_en && (pack_count == '0);
      band_pack_last  <= fifo_both_read_en && pack_last_rd;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) next_state = READ_MEASURE;
      end
      READ_MEASURE: begin
        if (fifo_measure_complete) next_state = COMPUTE_MSE;
      end
      COMPUTE_MSE: begin
        if (fifo_both_read_en && pack_last_rd && vctr_last) next_state = WAIT_MSE;
      end
      WAIT_MSE: begin
        if (msi_valid) next_state = COMPARE_MSE;  // Pipeline has started to deliver
      end
      COMPARE_MSE: begin
        if (msi_comparison_valid) next_state = DONE;
      end
      DONE: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/hsid_measure_buf.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_measure_buf
  import hsid_pkg::*;
#(
  parameter int HSP_BANDS_WIDTH = `HSID_HSP_BANDS_WIDTH,
  localparam int PACK_WIDTH =
    HSP_BANDS_WIDTH - $clog2(`HSID_WORD_WIDTH / `HSID_DATA_WIDTH),
  localparam int DEPTH = (1 << PACK_WIDTH) - 1  // Longest vector
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  hsid_word_u            wr_data,
  input  logic [PACK_WIDTH-1:0] band_pack_threshold,
  input  logic                  rd_en,
  input  logic                  clear,                // Restart fill and replay
  output logic                  complete,
  output logic                  empty,
  output hsid_word_u            rd_data
);

  logic [$bits(hsid_word_u)-1:0] mem [DEPTH];
  logic [PACK_WIDTH-1:0]         wr_count;
  logic [PACK_WIDTH-1:0]         rd_ptr;
  logic                          wr_accept;

  assign complete  = (wr_count == band_pack_threshold);
  assign empty     = (wr_count == '0);
  assign wr_accept = wr_en && !complete;  // Extra words past the vector are ignored

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[wr_count] <= wr_data.raw;
    end
    if (rd_en) begin
      rd_data.raw <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_count <= '0;
      rd_ptr   <= '0;
    end else if (clear) begin
      wr_count <= '0;
      rd_ptr   <= '0;
    end else begin
      if (wr_accept) begin
        wr_count <= wr_count + 1'b1;
      end
      if (rd_en) begin
        // Replay from the first pack for the next library vector
        rd_ptr <= (rd_ptr == band_pack_threshold - 1'b1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/hsid_ref_fifo.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_ref_fifo
  import hsid_pkg::*;
#(
  parameter int DEPTH = `HSID_REF_FIFO_DEPTH,  // Power of two
  localparam int PTR_WIDTH = $clog2(DEPTH)
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  hsid_word_u wr_data,
  input  logic       rd_en,
  output hsid_word_u rd_data,
  output logic       empty,
  output logic       credit    // One pulse per popped word
);

  logic [$bits(hsid_word_u)-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0]          wr_ptr;
  logic [PTR_WIDTH-1:0]          rd_ptr;
  logic [PTR_WIDTH:0]            fill_count;
  logic                          full;
  logic                          push;
  logic                          pop;

  assign full  = (fill_count == (PTR_WIDTH + 1)'(DEPTH));
  assign empty = (fill_count == '0);
  assign push  = wr_en && !full;
  assign pop   = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data.raw;
    end
    if (pop) begin
      rd_data.raw <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
      credit     <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
      credit <= pop;  // Slot is free again
    end
  end

endmodule

`default_nettype wire

/* source/hsid_sq_diff_acc.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_sq_diff_acc
  import hsid_pkg::*;
#(
  parameter int HSP_LIBRARY_WIDTH = `HSID_HSP_LIBRARY_WIDTH,
  parameter int MSE_WIDTH         = `HSID_MSE_WIDTH
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  hsid_word_u                   meas_word,
  input  hsid_word_u                   ref_word,
  input  logic                         band_pack_valid,
  input  logic                         band_pack_start,
  input  logic                         band_pack_last,
  input  logic [HSP_LIBRARY_WIDTH-1:0] vctr_index,
  output logic                         msi_valid,
  output logic [MSE_WIDTH-1:0]         mse,
  output logic [HSP_LIBRARY_WIDTH-1:0] mse_index
);

  localparam int SAMPLE_WIDTH   = `HSID_DATA_WIDTH;
  localparam int PACK_SUM_WIDTH = 2 * SAMPLE_WIDTH + $clog2(HSID_SAMPLES_PER_WORD);

  logic [SAMPLE_WIDTH-1:0]      abs_diff [HSID_SAMPLES_PER_WORD];
  logic [2*SAMPLE_WIDTH-1:0]    sq       [HSID_SAMPLES_PER_WORD];
  logic [PACK_SUM_WIDTH-1:0]    pack_sum;
  logic                         s1_valid;
  logic                         s1_start;
  logic                         s1_last;
  logic [PACK_SUM_WIDTH-1:0]    s1_sum;
  logic [HSP_LIBRARY_WIDTH-1:0] s1_index;
  logic [MSE_WIDTH-1:0]         acc;
  logic [MSE_WIDTH-1:0]         acc_next;

  // Squared error of the four bands in one pack
  always_comb begin
    pack_sum = '0;
    for (int i = 0; i < HSID_SAMPLES_PER_WORD; i++) begin
      abs_diff[i] = (meas_word.samples[i] > ref_word.samples[i]) ?
                    meas_word.samples[i] - ref_word.samples[i] :
                    ref_word.samples[i] - meas_word.samples[i];
      sq[i]       = abs_diff[i] * abs_diff[i];
      pack_sum    = pack_sum + sq[i];
    end
  end

  assign acc_next = s1_start ? MSE_WIDTH'(s1_sum) : acc + s1_sum;  // First pack loads

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_start  <= 1'b0;
      s1_last   <= 1'b0;
      msi_valid <= 1'b0;
    end else begin
      s1_valid  <= band_pack_valid;
      s1_start  <= band_pack_valid && band_pack_start;
      s1_last   <= band_pack_valid && band_pack_last;
      msi_valid <= s1_valid && s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (band_pack_valid) begin
      s1_sum   <= pack_sum;
      s1_index <= vctr_index;  // Index rides along with its pack
    end
    if (s1_valid) begin
      acc <= acc_next;
    end
    if (s1_valid && s1_last) begin
      mse       <= acc_next;
      mse_index <= s1_index;
    end
  end

endmodule

`default_nettype wire

/* source/hsid_min_compare.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_min_compare
  import hsid_pkg::*;
#(
  parameter int HSP_LIBRARY_WIDTH = `HSID_HSP_LIBRARY_WIDTH,
  parameter int MSE_WIDTH         = `HSID_MSE_WIDTH
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic                         msi_valid,
  input  logic [MSE_WIDTH-1:0]         mse,
  input  logic [HSP_LIBRARY_WIDTH-1:0] mse_index,
  input  logic [HSP_LIBRARY_WIDTH-1:0] last_index,  // Library size minus one
  output logic [MSE_WIDTH-1:0]         best_mse,
  output logic [HSP_LIBRARY_WIDTH-1:0] best_index,
  output logic                         msi_comparison_valid
);

  logic better;

  assign better = (mse < best_mse);  // Strict compare so the earlier index keeps a tie

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best_mse             <= '1;
      best_index           <= '0;
      msi_comparison_valid <= 1'b0;
    end else begin
      msi_comparison_valid <= msi_valid && (mse_index == last_index);
      if (start) begin
        best_mse   <= '1;  // Any real distance beats this
        best_index <= '0;
      end else if (msi_valid && better) begin
        best_mse   <= mse;
        best_index <= mse_index;
      end
    end
  end

endmodule

`default_nettype wire

/* source/hsid_top.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_top
  import hsid_pkg::*;
#(
  parameter int HSP_BANDS_WIDTH   = `HSID_HSP_BANDS_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = `HSID_HSP_LIBRARY_WIDTH,
  parameter int MSE_WIDTH         = `HSID_MSE_WIDTH,
  parameter int REF_FIFO_DEPTH    = `HSID_REF_FIFO_DEPTH,
  localparam int WORD_WIDTH = $bits(hsid_word_u),
  localparam int PACK_WIDTH =
    HSP_BANDS_WIDTH - $clog2(`HSID_WORD_WIDTH / `HSID_DATA_WIDTH)
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [HSP_LIBRARY_WIDTH-1:0] hsi_library_size,
  input  logic [PACK_WIDTH-1:0]        band_pack_threshold,
  input  logic                         measure_valid,
  input  logic [WORD_WIDTH-1:0]        measure_data,
  input  logic                         ref_valid,
  input  logic [WORD_WIDTH-1:0]        ref_data,
  output logic                         ref_credit,
  output logic                         idle,
  output logic                         done,
  output logic [HSP_LIBRARY_WIDTH-1:0] best_index,
  output logic [MSE_WIDTH-1:0]         best_mse
);

  hsid_main_state_t             state;
  hsid_word_u                   measure_word;
  hsid_word_u                   ref_word;
  hsid_word_u                   meas_rd_word;
  hsid_word_u                   ref_rd_word;
  logic                         measure_wr_en;
  logic                         fifo_measure_complete;
  logic                         fifo_ref_empty;
  logic                         fifo_both_read_en;
  logic                         band_pack_start;
  logic                         band_pack_last;
  logic                         band_pack_valid;
  logic [HSP_LIBRARY_WIDTH-1:0] vctr_count;
  logic [HSP_LIBRARY_WIDTH-1:0] last_index;
  logic                         msi_valid;
  logic [MSE_WIDTH-1:0]         mse;
  logic [HSP_LIBRARY_WIDTH-1:0] mse_index;
  logic                         msi_comparison_valid;

  assign measure_word.raw = measure_data;
  assign ref_word.raw     = ref_data;
  assign measure_wr_en    = measure_valid && (state == READ_MEASURE);  // Load window only
  assign last_index       = hsi_library_size - 1'b1;

  hsid_main_fsm #(
    .HSP_BANDS_WIDTH  (HSP_BANDS_WIDTH),
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH)
  ) u_main_fsm (
    .clk                  (clk),
    .rst_n                (rst_n),
    .hsi_library_size     (hsi_library_size),
    .band_pack_threshold  (band_pack_threshold),
    .fifo_measure_complete(fifo_measure_complete),
    .fifo_ref_empty       (fifo_ref_empty),
    .msi_valid            (msi_valid),
    .msi_comparison_valid (msi_comparison_valid),
    .start                (start),
    .state                (state),
    .vctr_count           (vctr_count),
    .band_pack_start      (band_pack_start),
    .band_pack_last       (band_pack_last),
    .band_pack_valid      (band_pack_valid),
    .vctr_last            (),
    .fifo_both_read_en    (fifo_both_read_en),
    .done                 (done),
    .idle                 (idle)
  );

  hsid_measure_buf #(
    .HSP_BANDS_WIDTH(HSP_BANDS_WIDTH)
  ) u_measure_buf (
    .clk                (clk),
    .rst_n              (rst_n),
    .wr_en              (measure_wr_en),
    .wr_data            (measure_word),
    .band_pack_threshold(band_pack_threshold),
    .rd_en              (fifo_both_read_en),
    .clear              (idle),  // Refill on every run
    .complete           (fifo_measure_complete),
    .empty              (),
    .rd_data            (meas_rd_word)
  );

  hsid_ref_fifo #(
    .DEPTH(REF_FIFO_DEPTH)
  ) u_ref_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (ref_valid),
    .wr_data(ref_word),
    .rd_en  (fifo_both_read_en),
    .rd_data(ref_rd_word),
    .empty  (fifo_ref_empty),
    .credit (ref_credit)
  );

  hsid_sq_diff_acc #(
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH),
    .MSE_WIDTH        (MSE_WIDTH)
  ) u_sq_diff_acc (
    .clk            (clk),
    .rst_n          (rst_n),
    .meas_word      (meas_rd_word),
    .ref_word       (ref_rd_word),
    .band_pack_valid(band_pack_valid),
    .band_pack_start(band_pack_start),
    .band_pack_last (band_pack_last),
    .vctr_index     (vctr_count),
    .msi_valid      (msi_valid),
    .mse            (mse),
    .mse_index      (mse_index)
  );

  hsid_min_compare #(
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH),
    .MSE_WIDTH        (MSE_WIDTH)
  ) u_min_compare (
    .clk                 (clk),
    .rst_n               (rst_n),
    .start               (start),
    .msi_valid           (msi_valid),
    .mse                 (mse),
    .mse_index           (mse_index),
    .last_index          (last_index),
    .best_mse            (best_mse),
    .best_index          (best_index),
    .msi_comparison_valid(msi_comparison_valid)
  );

endmodule

`default_nettype wire

/* tb/hsid_sva.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_sva
  import hsid_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input logic             done,
  input logic             ref_valid,
  input logic             fifo_both_read_en,
  input hsid_main_state_t state
);

  logic [7:0] ref_entries;  // Words sent and not yet popped
  bit         failed;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_entries <= '0;
    end else begin
      ref_entries <= ref_entries + 8'(ref_valid) - 8'(fifo_both_read_en);
    end
  end

  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      failed = 1'b1;
      $error("done stayed high for more than one cycle");
    end

  ref_fifo_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    ref_entries <= `HSID_REF_FIFO_DEPTH)
    else begin
      failed = 1'b1;
      $error("reference FIFO holds more words than its depth");
    end

  read_only_in_compute: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_both_read_en |-> state == COMPUTE_MSE)
    else begin
      failed = 1'b1;
      $error("buffer read outside COMPUTE_MSE");
    end

endmodule

bind hsid_top hsid_sva u_sva (
  .clk              (clk),
  .rst_n            (rst_n),
  .done             (done),
  .ref_valid        (ref_valid),
  .fifo_both_read_en(fifo_both_read_en),
  .state            (state)
);

`default_nettype wire

/* tb/hsid_tb.sv */
`default_nettype none

`include "hsid_config.svh"

module hsid_tb;

  localparam int PACK_WIDTH  = `HSID_HSP_BANDS_WIDTH - 2;
  localparam int LIB_WIDTH   = `HSID_HSP_LIBRARY_WIDTH;
  localparam int MAX_PACKS   = 63;
  localparam int MAX_VCTRS   = 20;
  localparam int NUM_RUNS    = 9;
  localparam int CYCLE_LIMIT = NUM_RUNS * (MAX_PACKS + MAX_VCTRS * MAX_PACKS * 4 + 50);

  logic                         clk;
  logic                         rst_n;
  logic                         start;
  logic [LIB_WIDTH-1:0]         hsi_library_size;
  logic [PACK_WIDTH-1:0]        band_pack_threshold;
  logic                         measure_valid;
  logic [`HSID_WORD_WIDTH-1:0]  measure_data;
  logic                         ref_valid;
  logic [`HSID_WORD_WIDTH-1:0]  ref_data;
  logic                         ref_credit;
  logic                         idle;
  logic                         done;
  logic [LIB_WIDTH-1:0]         best_index;
  logic [`HSID_MSE_WIDTH-1:0]   best_mse;

  logic [`HSID_WORD_WIDTH-1:0]  meas_vec [MAX_PACKS];
  logic [`HSID_WORD_WIDTH-1:0]  ref_lib  [MAX_VCTRS * MAX_PACKS];  // Vector v at v * MAX_PACKS
  logic [31:0]                  lfsr;
  int                           credits;      // Host side credit count
  int                           ref_sent;     // All reference words sent so far
  int                           ref_total;    // Words the runs so far ask for
  int                           cycle_count;
  bit                           no_pause;

  hsid_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .start              (start),
    .hsi_library_size   (hsi_library_size),
    .band_pack_threshold(band_pack_threshold),
    .measure_valid      (measure_valid),
    .measure_data       (measure_data),
    .ref_valid          (ref_valid),
    .ref_data           (ref_data),
    .ref_credit         (ref_credit),
    .idle               (idle),
    .done               (done),
    .best_index         (best_index),
    .best_mse           (best_mse)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic step_lfsr();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) val = {val[30:0], step_lfsr()};
    return val;
  endfunction

  function automatic int vector_sse(input int v, input int packs);
    int sum;
    int d;
    sum = 0;
    for (int p = 0; p < packs; p++) begin
      for (int b = 0; b < 4; b++) begin
        d = int'(meas_vec[p][8*b +: 8]) - int'(ref_lib[v * MAX_PACKS + p][8*b +: 8]);
        sum += d * d;
      end
    end
    return sum;
  endfunction

  // Credits, sent words, done ordering and the run limit
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits     <= `HSID_REF_FIFO_DEPTH;
      ref_sent    <= 0;
      cycle_count <= 0;
    end else begin
      credits     <= credits - int'(ref_valid) + int'(ref_credit);
      ref_sent    <= ref_sent + int'(ref_valid);
      cycle_count <= cycle_count + 1;
      assert (cycle_count < CYCLE_LIMIT)
        else report_failure($sformatf("timeout, no result after %0d cycles", cycle_count));
      assert (!uut.u_sva.failed)
        else report_failure("a bound assertion on the DUT failed");
      if (done) begin
        assert (ref_sent == ref_total)
          else report_failure("done came before every reference word was sent");
      end
    end
  end

  task automatic fill_random(input int packs, input int vctrs);
    for (int p = 0; p < packs; p++) meas_vec[p] = rand_bits(32);
    for (int v = 0; v < vctrs; v++) begin
      for (int p = 0; p < packs; p++) ref_lib[v * MAX_PACKS + p] = rand_bits(32);
    end
  endtask

  // Two copies of a vector one step away from the measure in every band
  task automatic plant_tie(input int packs, input int lo, input int hi);
    for (int p = 0; p < packs; p++) begin
      ref_lib[lo * MAX_PACKS + p] = meas_vec[p] ^ 32'h0101_0101;
      ref_lib[hi * MAX_PACKS + p] = meas_vec[p] ^ 32'h0101_0101;
    end
  endtask

  task automatic wait_gap();
    int gap;
    gap = 0;
    if (!no_pause && rand_bits(1) == 1) gap = 1 + int'(rand_bits(1));
    repeat (gap) @(negedge clk);
  endtask

  task automatic send_measure(input int packs);
    for (int p = 0; p < packs; p++) begin
      wait_gap();
      measure_valid = 1'b1;
      measure_data  = meas_vec[p];
      @(negedge clk);
      measure_valid = 1'b0;
    end
  endtask

  task automatic send_refs(input int packs, input int words);
    for (int w = 0; w < words; w++) begin
      wait_gap();
      while (credits == 0) @(negedge clk);  // Hold until a slot is free
      ref_valid = 1'b1;
      ref_data  = ref_lib[(w / packs) * MAX_PACKS + (w % packs)];
      @(negedge clk);
      ref_valid = 1'b0;
    end
  endtask

  task automatic run_case(input int packs, input int vctrs, input bit steady);
    int exp_index;
    int exp_sse;
    int sse;
    exp_index = 0;
    exp_sse   = vector_sse(0, packs);
    for (int v = 1; v < vctrs; v++) begin
      sse = vector_sse(v, packs);
      if (sse < exp_sse) begin  // Strict compare so the lower index keeps a tie
        exp_sse   = sse;
        exp_index = v;
      end
    end
    no_pause            = steady;
    ref_total           = ref_total + packs * vctrs;
    band_pack_threshold = PACK_WIDTH'(packs);
    hsi_library_size    = LIB_WIDTH'(vctrs);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    fork
      send_measure(packs);
      send_refs(packs, packs * vctrs);
    join
    while (!done) @(negedge clk);
    assert (int'(best_index) == exp_index)
      else report_failure($sformatf("MISMATCH at %0t: best_index %0d, expected %0d",
                                    $time, best_index, exp_index));
    assert (int'(best_mse) == exp_sse)
      else report_failure($sformatf("MISMATCH at %0t: best_mse %0d, expected %0d",
                                    $time, best_mse, exp_sse));
    assert (credits == `HSID_REF_FIFO_DEPTH)
      else report_failure("reference credits were not all returned at done");
    @(negedge clk);
    assert (idle) else report_failure("engine did not return to idle after done");
  endtask

  initial begin
    int packs;
    int vctrs;
    lfsr                = 32'h3ee3_ef14;
    rst_n               = 1'b0;
    start               = 1'b0;
    hsi_library_size    = '0;
    band_pack_threshold = '0;
    measure_valid       = 1'b0;
    measure_data        = '0;
    ref_valid           = 1'b0;
    ref_data            = '0;
    ref_total           = 0;
    no_pause            = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    assert (idle && !done && !ref_credit)
      else report_failure("outputs after reset are not idle with done and credit low");

    for (int r = 0; r < 6; r++) begin
      packs = int'(rand_bits(6));
      if (packs == 0) packs = 1;
      vctrs = int'(rand_bits(5)) % MAX_VCTRS + 1;
      fill_random(packs, vctrs);
      run_case(packs, vctrs, 1'b0);
    end

    fill_random(16, 12);
    plant_tie(16, 3, 9);
    run_case(16, 12, 1'b0);
    assert (best_index == LIB_WIDTH'(3))
      else report_failure($sformatf("MISMATCH at %0t: tie won by index %0d, expected 3",
                                    $time, best_index));

    fill_random(1, 1);
    run_case(1, 1, 1'b0);
    fill_random(MAX_PACKS, MAX_VCTRS);
    run_case(MAX_PACKS, MAX_VCTRS, 1'b1);  // FIFO runs full

    assert (!uut.u_sva.failed)
      else report_failure("a bound assertion on the DUT failed");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/hsid_pkg.sv
source/hsid_main_fsm.sv
source/hsid_measure_buf.sv
source/hsid_ref_fifo.sv
source/hsid_sq_diff_acc.sv
source/hsid_min_compare.sv
source/hsid_top.sv
tb/hsid_sva.sv
tb/hsid_tb.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vhsid_tb: src.f $(wildcard source/*.sv source/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module hsid_tb

run: obj_dir/Vhsid_tb
	./obj_dir/Vhsid_tb

clean:
	rm -rf obj_dir
